//--- files.f
+incdir+test
rtl/fmac_rx_pkg.sv
rtl/xgmii_rx_parser.sv
rtl/rx_pkt_buffer.sv
rtl/rx_pkt_reader.sv
rtl/fmac_rx_core.sv
test/tb_fmac_rx.sv

//--- rtl/fmac_rx_core.sv
/*
 * 10G MAC receive core
 * xgmii parser -> packet buffer -> user reader
 */

`timescale 1ns/1ps
`default_nettype none

module fmac_rx_core (
	input  wire                               usr_clk,
	input  wire                               usr_rst_,
	input  wire                               rx_en,
	input  wire [fmac_rx_pkg::DATA_W-1:0]     xgmii_rxd,
	input  wire [fmac_rx_pkg::LANES-1:0]      xgmii_rxc,
	input  wire                               rx_ready,
	output wire                               rx_valid,
	output wire [fmac_rx_pkg::DATA_W-1:0]     rx_data,
	output wire                               rx_start,
	output wire                               rx_end,
	output wire [fmac_rx_pkg::BCNT_W-1:0]     rx_bcnt,
	output wire                               rx_err,
	output wire [fmac_rx_pkg::CNT_W-1:0]      rx_pkt_cnt,
	output wire [fmac_rx_pkg::CNT_W-1:0]      rx_byte_cnt,
	output wire [fmac_rx_pkg::CNT_W-1:0]      rx_err_cnt,
	output wire [fmac_rx_pkg::CNT_W-1:0]      rx_drop_cnt
);

	import fmac_rx_pkg::*;

	// parser to buffer
	wire                wr_en;
	wire [DATA_W-1:0]   wr_data;
	wire                wr_start;
	wire                wr_end;
	wire [BCNT_W-1:0]   wr_bcnt;
	wire                wr_err;
	wire [FREE_W-1:0]   free_cnt;
	wire                drop_pulse;	// also to reader counters

	// buffer to reader
	wire [DATA_W-1:0]   head_data;
	wire                head_start;
	wire                head_end;
	wire [BCNT_W-1:0]   head_bcnt;
	wire                head_err;
	wire                empty;
	wire                rd_en;

	xgmii_rx_parser parser (
		.usr_clk    (usr_clk),
		.usr_rst_   (usr_rst_),
		.rx_en      (rx_en),
		.xgmii_rxd  (xgmii_rxd),
		.xgmii_rxc  (xgmii_rxc),
		.free_cnt   (free_cnt),
		.wr_en      (wr_en),
		.wr_data    (wr_data),
		.wr_start   (wr_start),
		.wr_end     (wr_end),
		.wr_bcnt    (wr_bcnt),
		.wr_err     (wr_err),
		.drop_pulse (drop_pulse)
	);

	rx_pkt_buffer buffer (
		.usr_clk    (usr_clk),
		.usr_rst_   (usr_rst_),
		.wr_en      (wr_en),
		.wr_data    (wr_data),
		.wr_start   (wr_start),
		.wr_end     (wr_end),
		.wr_bcnt    (wr_bcnt),
		.wr_err     (wr_err),
		.rd_en      (rd_en),
		.head_data  (head_data),
		.head_start (head_start),
		.head_end   (head_end),
		.head_bcnt  (head_bcnt),
		.head_err   (head_err),
		.empty      (empty),
		.free_cnt   (free_cnt)
	);

	rx_pkt_reader reader (
		.usr_clk     (usr_clk),
		.usr_rst_    (usr_rst_),
		.head_data   (head_data),
		.head_start  (head_start),
		.head_end    (head_end),
		.head_bcnt   (head_bcnt),
		.head_err    (head_err),
		.empty       (empty),
		.drop_pulse  (drop_pulse),
		.rx_ready    (rx_ready),
		.rd_en       (rd_en),
		.rx_valid    (rx_valid),
		.rx_data     (rx_data),
		.rx_start    (rx_start),
		.rx_end      (rx_end),
		.rx_bcnt     (rx_bcnt),
		.rx_err      (rx_err),
		.rx_pkt_cnt  (rx_pkt_cnt),
		.rx_byte_cnt (rx_byte_cnt),
		.rx_err_cnt  (rx_err_cnt),
		.rx_drop_cnt (rx_drop_cnt)
	);

endmodule

`default_nettype wire

//--- rtl/fmac_rx_pkg.sv
/*
 * shared definitions for the 10G MAC receive path
 * xgmii control characters, beat and counter widths,
 * packet buffer sizing and the parser state type
 */

`default_nettype none

package fmac_rx_pkg;

	// ========================================
	// xgmii control characters
	// ========================================
	localparam logic [7:0] XGMII_IDLE  = 8'h07;	// inter-frame fill
	localparam logic [7:0] XGMII_START = 8'hFB;	// lane 0 only
	localparam logic [7:0] XGMII_TERM  = 8'hFD;	// any lane
	localparam logic [7:0] XGMII_ERROR = 8'hFE;	// line error

	// ========================================
	// widths
	// ========================================
	localparam int DATA_W = 64;	// one xgmii beat
	localparam int LANES  = 8;	// byte lanes per beat
	localparam int BCNT_W = 3;	// 0 means all 8 bytes valid
	localparam int CNT_W  = 32;	// statistics counters

	// ========================================
	// packet buffer sizing
	// ========================================
	localparam int RX_BUF_DEPTH = 64;	// entries
	localparam int RX_BUF_AW    = 6;	// log2 of depth
	localparam int FREE_W       = RX_BUF_AW + 1;	// free count reaches depth
	localparam int RX_MAX_BEATS = 16;	// 128 byte frame body
	localparam int BEAT_W       = 5;	// beat counter, holds RX_MAX_BEATS

	// parser states
	typedef enum logic [1:0] {
		PS_IDLE,	// waiting for start
		PS_DATA,	// admitted frame in progress
		PS_DISCARD	// dropped or cut, skip to terminate
	} parse_state_e;

endpackage

`default_nettype wire

//--- rtl/rx_pkt_buffer.sv
/*
 * receive packet buffer
 * synchronous FIFO of data beats with a sidecar array for
 * start/end/bcnt/err, plus free entry count for admission
 */

`timescale 1ns/1ps
`default_nettype none

module rx_pkt_buffer (
	input  wire                               usr_clk,
	input  wire                               usr_rst_,
	input  wire                               wr_en,
	input  wire [fmac_rx_pkg::DATA_W-1:0]     wr_data,
	input  wire                               wr_start,
	input  wire                               wr_end,
	input  wire [fmac_rx_pkg::BCNT_W-1:0]     wr_bcnt,
	input  wire                               wr_err,
	input  wire                               rd_en,	// pop head
	output logic [fmac_rx_pkg::DATA_W-1:0]    head_data,
	output logic                              head_start,
	output logic                              head_end,
	output logic [fmac_rx_pkg::BCNT_W-1:0]    head_bcnt,
	output logic                              head_err,
	output logic                              empty,
	output logic [fmac_rx_pkg::FREE_W-1:0]    free_cnt
);

	import fmac_rx_pkg::*;

	localparam int CTRL_W = BCNT_W + 3;	// start, end, err, bcnt

	logic [DATA_W-1:0]     data_mem [RX_BUF_DEPTH];
	logic [CTRL_W-1:0]     ctrl_mem [RX_BUF_DEPTH];	// sidecar beside data
	logic [RX_BUF_AW-1:0]  wr_ptr;	// wraps at depth
	logic [RX_BUF_AW-1:0]  rd_ptr;
	logic [FREE_W-1:0]     count;	// occupancy
	logic                  full;
	logic                  do_wr;
	logic                  do_rd;

	assign empty    = (count == '0);
	assign full     = (count == FREE_W'(RX_BUF_DEPTH));
	assign free_cnt = FREE_W'(RX_BUF_DEPTH) - count;
	assign do_wr    = wr_en && !full;
	assign do_rd    = rd_en && !empty;

	// head entry read straight from the arrays
	assign head_data = data_mem[rd_ptr];
	assign {head_start, head_end, head_err, head_bcnt} = ctrl_mem[rd_ptr];

	// storage
	always_ff @(posedge usr_clk)
	begin
		if (do_wr)
		begin
			data_mem[wr_ptr] <= wr_data;
			ctrl_mem[wr_ptr] <= {wr_start, wr_end, wr_err, wr_bcnt};
		end
	end

	// ========================================
	// pointers and occupancy
	// ========================================
	always_ff @(posedge usr_clk)
	begin
		if (!usr_rst_)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_wr, do_rd})
			2'b10:   count <= count + 1'b1;
			2'b01:   count <= count - 1'b1;
			default: count <= count;	// both or neither
			endcase
		end
	end

endmodule

`default_nettype wire

//--- rtl/rx_pkt_reader.sv
/*
 * receive packet reader
 * pops the packet buffer into a valid/ready output register
 * and keeps packet, byte, error and drop counters
 */

`timescale 1ns/1ps
`default_nettype none

module rx_pkt_reader (
	input  wire                               usr_clk,
	input  wire                               usr_rst_,
	input  wire [fmac_rx_pkg::DATA_W-1:0]     head_data,
	input  wire                               head_start,
	input  wire                               head_end,
	input  wire [fmac_rx_pkg::BCNT_W-1:0]     head_bcnt,
	input  wire                               head_err,
	input  wire                               empty,
	input  wire                               drop_pulse,	// from parser
	input  wire                               rx_ready,
	output logic                              rd_en,
	output logic                              rx_valid,
	output logic [fmac_rx_pkg::DATA_W-1:0]    rx_data,
	output logic                              rx_start,
	output logic                              rx_end,
	output logic [fmac_rx_pkg::BCNT_W-1:0]    rx_bcnt,
	output logic                              rx_err,
	output logic [fmac_rx_pkg::CNT_W-1:0]     rx_pkt_cnt,
	output logic [fmac_rx_pkg::CNT_W-1:0]     rx_byte_cnt,
	output logic [fmac_rx_pkg::CNT_W-1:0]     rx_err_cnt,
	output logic [fmac_rx_pkg::CNT_W-1:0]     rx_drop_cnt
);

	import fmac_rx_pkg::*;

	logic              xfer;	// beat accepted by user
	logic [CNT_W-1:0]  beat_bytes;

	assign xfer       = rx_valid && rx_ready;
	assign rd_en      = !empty && (!rx_valid || rx_ready);	// slot free this edge
	assign beat_bytes = (rx_bcnt == '0) ? CNT_W'(LANES) : CNT_W'(rx_bcnt);

	// ========================================
	// output register
	// ========================================
	always_ff @(posedge usr_clk)
	begin
		if (!usr_rst_)
			rx_valid <= 1'b0;
		else if (rd_en)
			rx_valid <= 1'b1;
		else if (rx_ready)
			rx_valid <= 1'b0;	// drained, nothing behind it
	end

	always_ff @(posedge usr_clk)
	begin
		if (rd_en)	// payload holds while stalled
		begin
			rx_data <= head_data;
			rx_start <= head_start;
			rx_end <= head_end;
			rx_bcnt <= head_bcnt;
			rx_err <= head_err;
		end
	end

	// ========================================
	// statistics
	// ========================================
	always_ff @(posedge usr_clk)
	begin
		if (!usr_rst_)
		begin
			rx_pkt_cnt <= '0;
			rx_byte_cnt <= '0;
			rx_err_cnt <= '0;
			rx_drop_cnt <= '0;
		end
		else
		begin
			if (xfer)
				rx_byte_cnt <= rx_byte_cnt + beat_bytes;
			if (xfer && rx_end)
				rx_pkt_cnt <= rx_pkt_cnt + 1'b1;	// counted at frame end
			if (xfer && rx_end && rx_err)
				rx_err_cnt <= rx_err_cnt + 1'b1;	// oversize or bad char
			if (drop_pulse)
				rx_drop_cnt <= rx_drop_cnt + 1'b1;	// overrun or disabled
		end
	end

endmodule

`default_nettype wire

//--- rtl/xgmii_rx_parser.sv
/*
 * xgmii receive parser
 * finds start/terminate framing, packs 64-bit beats with
 * start/end/bcnt/err sidecar, reserves buffer room per frame
 */

`timescale 1ns/1ps
`default_nettype none

module xgmii_rx_parser (
	input  wire                                usr_clk,
	input  wire                                usr_rst_,
	input  wire                                rx_en,	// admit new frames
	input  wire [fmac_rx_pkg::DATA_W-1:0]      xgmii_rxd,
	input  wire [fmac_rx_pkg::LANES-1:0]       xgmii_rxc,
	input  wire [fmac_rx_pkg::FREE_W-1:0]      free_cnt,	// from buffer
	output logic                               wr_en,
	output logic [fmac_rx_pkg::DATA_W-1:0]     wr_data,
	output logic                               wr_start,
	output logic                               wr_end,
	output logic [fmac_rx_pkg::BCNT_W-1:0]     wr_bcnt,
	output logic                               wr_err,
	output logic                               drop_pulse	// one per dropped frame
);

	import fmac_rx_pkg::*;

	parse_state_e          state;
	logic [LANES-1:0]      term_hit;	// lanes holding a terminate
	logic [LANES-1:0]      below_mask;	// lanes before the first terminate
	logic [BCNT_W-1:0]     term_lane;	// lowest terminate lane
	logic                  term_any;
	logic                  start_in;
	logic                  ctrl_err;	// stray control char in frame bytes
	logic [DATA_W-1:0]     keep_data;	// bytes past terminate zeroed
	logic                  room_ok;
	logic                  flush;	// held terminate beat ready to go
	logic                  cut;	// oversize cut on this write

	// pending beat
	logic                  hold_vld;
	logic [DATA_W-1:0]     hold_data;
	logic                  hold_end;
	logic [BCNT_W-1:0]     hold_bcnt;

	logic [BEAT_W-1:0]     beat_cnt;	// beats written this frame
	logic                  err_flag;	// sticky per frame

	// ========================================
	// lane decode
	// ========================================
	always_comb
	begin
		for (int i = 0; i < LANES; i++)
			term_hit[i] = xgmii_rxc[i] && (xgmii_rxd[8*i +: 8] == XGMII_TERM);
	end

	always_comb
	begin
		term_lane = '0;
		below_mask = '1;	// no terminate, whole beat is data
		for (int i = LANES - 1; i >= 0; i--)	// downward so lowest lane wins
		begin
			if (term_hit[i])
			begin
				term_lane = BCNT_W'(i);
				below_mask = ~({LANES{1'b1}} << i);
			end
		end
	end

	always_comb
	begin
		for (int i = 0; i < LANES; i++)
			keep_data[8*i +: 8] = below_mask[i] ? xgmii_rxd[8*i +: 8] : 8'h00;
	end

	assign term_any = |term_hit;
	assign start_in = xgmii_rxc[0] && (xgmii_rxd[7:0] == XGMII_START);
	assign ctrl_err = |(xgmii_rxc & below_mask);	// includes XGMII_ERROR
	assign flush    = hold_vld && hold_end;
	assign cut      = hold_vld && (beat_cnt == BEAT_W'(RX_MAX_BEATS - 1));

	// room for a max frame beyond the writes still in flight
	assign room_ok = (free_cnt >= FREE_W'(RX_MAX_BEATS) + FREE_W'(wr_en) + FREE_W'(flush));

	// ========================================
	// frame FSM and write port
	// ========================================
	always_ff @(posedge usr_clk)
	begin
		if (!usr_rst_)
		begin
			state <= PS_IDLE;
			hold_vld <= 1'b0;
			beat_cnt <= '0;
			err_flag <= 1'b0;
			wr_en <= 1'b0;
			drop_pulse <= 1'b0;
		end
		else
		begin
			wr_en <= 1'b0;
			drop_pulse <= 1'b0;

			if (flush)	// term beat needs no lookahead
			begin
				wr_en <= 1'b1;
				wr_data <= hold_data;
				wr_start <= (beat_cnt == '0);
				wr_end <= 1'b1;
				wr_bcnt <= hold_bcnt;
				wr_err <= err_flag;
				hold_vld <= 1'b0;
			end

			case (state)
			PS_IDLE:
			begin
				if (start_in)	// preamble beat itself is dropped
				begin
					if (rx_en && room_ok)
					begin
						state <= PS_DATA;
						beat_cnt <= '0;
						err_flag <= 1'b0;
					end
					else
					begin
						state <= PS_DISCARD;	// whole frame lost
						drop_pulse <= 1'b1;
					end
				end
			end

			PS_DATA:
			begin
				err_flag <= err_flag | ctrl_err;
				if (term_any && (term_lane == '0))
				begin
					wr_en <= 1'b1;	// held beat closes the frame
					wr_data <= hold_vld ? hold_data : '0;
					wr_start <= (beat_cnt == '0);
					wr_end <= 1'b1;
					wr_bcnt <= '0;
					wr_err <= err_flag | !hold_vld;	// empty frame is an error
					hold_vld <= 1'b0;
					state <= PS_IDLE;
				end
				else
				begin
					if (hold_vld)	// next beat seen, held one is not last
					begin
						wr_en <= 1'b1;
						wr_data <= hold_data;
						wr_start <= (beat_cnt == '0);
						wr_end <= cut;
						wr_bcnt <= '0;
						wr_err <= cut;
						beat_cnt <= beat_cnt + 1'b1;
					end
					hold_vld <= !cut;	// after a cut nothing more is kept
					hold_data <= keep_data;
					hold_end <= term_any;
					hold_bcnt <= term_lane;
					if (term_any)
						state <= PS_IDLE;
					else if (cut)
						state <= PS_DISCARD;	// rest of oversize frame
				end
			end

			default:	// PS_DISCARD
			begin
				if (term_any)
					state <= PS_IDLE;
			end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build and run the receive core testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_fmac_rx \
	-f files.f -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Regression failed" "$LOG"; then
	exit 1
fi
exit 0

//--- test/tb_xgmii_tasks.svh
/*
 * xgmii frame senders for the receive core testbench
 * drive start, data, terminate and idle beats, and queue
 * the beats the core should deliver for each admitted frame
 */

logic [7:0] frame_bytes [$];	// payload of the frame being sent

// one xgmii beat, applied on the falling edge
task automatic drive_beat(input logic [DATA_W-1:0] d, input logic [LANES-1:0] c);
	@(negedge usr_clk);
	xgmii_rxd = d;
	xgmii_rxc = c;
endtask

task automatic send_idles(input int n);
	repeat (n) drive_beat({LANES{XGMII_IDLE}}, '1);
endtask

// ========================================
// expected beats of one admitted frame
// ========================================
task automatic push_expected(input bit bad);
	int               len;
	int               nb;
	int               pos;
	int               b;
	int               l;
	bit               trunc;
	logic             last;
	logic [DATA_W-1:0] d;
	logic [BCNT_W-1:0] bcnt;
	len = frame_bytes.size();
	nb = (len + LANES - 1) / LANES;
	trunc = (nb > RX_MAX_BEATS);	// cut at max, rest skipped
	if (trunc)
		nb = RX_MAX_BEATS;
	for (b = 0; b < nb; b++)
	begin
		d = '0;	// lanes past terminate read as zero
		for (l = 0; l < LANES; l++)
		begin
			pos = b * LANES + l;
			if (pos < len)
				d[8*l +: 8] = frame_bytes[pos];
		end
		last = (b == nb - 1);
		bcnt = (last && !trunc) ? BCNT_W'(len % LANES) : '0;
		exp_data.push_back(d);
		exp_flags.push_back({b == 0, last, last && (trunc || bad), bcnt});
		exp_bytes += (bcnt == '0) ? LANES : int'(bcnt);
	end
	exp_pkts++;
	if (trunc || bad)
		exp_errs++;
	room_used += nb;
endtask

// ========================================
// one frame: start, payload, terminate, idles
// ========================================
task automatic send_frame(input int len, input bit bad);
	logic [DATA_W-1:0] d;
	logic [LANES-1:0]  c;
	int                pos;
	int                occ;
	int                b;
	int                l;
	bit                admit;
	frame_bytes.delete();
	for (pos = 0; pos < len; pos++)
		frame_bytes.push_back(rand_byte());
	if (bad)
		frame_bytes[3] = XGMII_ERROR;	// error char in byte 3
	occ = (room_used > 0) ? room_used - 1 : 0;	// one beat parks in output reg
	admit = rx_en && (!track_room || (RX_BUF_DEPTH - occ >= RX_MAX_BEATS));
	if (admit)
		push_expected(bad);
	else
		exp_drops++;	// whole frame lost
	drive_beat({8'hD5, {6{8'h55}}, XGMII_START}, 8'h01);	// preamble + sfd
	for (b = 0; b <= len / LANES; b++)
	begin
		for (l = 0; l < LANES; l++)
		begin
			pos = b * LANES + l;
			if (pos < len)
			begin
				d[8*l +: 8] = frame_bytes[pos];
				c[l] = bad && (pos == 3);
			end
			else
			begin
				d[8*l +: 8] = (pos == len) ? XGMII_TERM : XGMII_IDLE;
				c[l] = 1'b1;
			end
		end
		drive_beat(d, c);
	end
	send_idles(IDLE_GAP);
endtask

//--- test/tb_fmac_rx.sv
/*
 * testbench for the 10G MAC receive core
 * clock, reset, watchdog, LFSR stimulus, beat scoreboard,
 * stall and counter checks
 */

`timescale 1ns/1ps
`default_nettype none

module tb_fmac_rx;

	import fmac_rx_pkg::*;

	localparam int IDLE_GAP        = 8;	// idles after each frame
	localparam int STALL_FRAMES    = 9;
	localparam int TEST_FRAMES     = 128 + 2 + 1 + STALL_FRAMES + 4;
	localparam int WATCHDOG_CYCLES = 200 * TEST_FRAMES + 2000;

	logic                usr_clk;
	logic                usr_rst_;
	logic                rx_en;
	logic [DATA_W-1:0]   xgmii_rxd;
	logic [LANES-1:0]    xgmii_rxc;
	logic                rx_ready;
	wire                 rx_valid;
	wire [DATA_W-1:0]    rx_data;
	wire                 rx_start;
	wire                 rx_end;
	wire [BCNT_W-1:0]    rx_bcnt;
	wire                 rx_err;
	wire [CNT_W-1:0]     rx_pkt_cnt;
	wire [CNT_W-1:0]     rx_byte_cnt;
	wire [CNT_W-1:0]     rx_err_cnt;
	wire [CNT_W-1:0]     rx_drop_cnt;

	// scoreboard
	logic [DATA_W-1:0]   exp_data [$];
	logic [BCNT_W+2:0]   exp_flags [$];	// start, end, err, bcnt
	int                  exp_pkts;
	int                  exp_bytes;
	int                  exp_errs;
	int                  exp_drops;
	int                  n_checks;
	int                  n_errors;
	string               test_name;

	logic [31:0]         pay_lfsr;	// payload bytes
	logic [31:0]         rdy_lfsr;	// rx_ready pattern
	int                  ready_mode;	// 0 high, 1 random, 2 low
	bit                  track_room;	// model buffer room while stalled
	int                  room_used;
	logic                stalled;
	logic [DATA_W-1:0]   stall_data;
	logic [BCNT_W+2:0]   stall_flags;

	fmac_rx_core uut (
		.usr_clk     (usr_clk),
		.usr_rst_    (usr_rst_),
		.rx_en       (rx_en),
		.xgmii_rxd   (xgmii_rxd),
		.xgmii_rxc   (xgmii_rxc),
		.rx_ready    (rx_ready),
		.rx_valid    (rx_valid),
		.rx_data     (rx_data),
		.rx_start    (rx_start),
		.rx_end      (rx_end),
		.rx_bcnt     (rx_bcnt),
		.rx_err      (rx_err),
		.rx_pkt_cnt  (rx_pkt_cnt),
		.rx_byte_cnt (rx_byte_cnt),
		.rx_err_cnt  (rx_err_cnt),
		.rx_drop_cnt (rx_drop_cnt)
	);

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [7:0] rand_byte();
		logic [7:0] v;
		for (int i = 0; i < 8; i++)
		begin
			pay_lfsr = lfsr_step(pay_lfsr);
			v[i] = pay_lfsr[0];	// one step per bit
		end
		return v;
	endfunction

	`include "tb_xgmii_tasks.svh"

	// ========================================
	// clock, rx_ready, watchdog
	// ========================================
	initial
	begin
		usr_clk = 1'b0;
		forever #20 usr_clk = ~usr_clk;
	end

	always @(negedge usr_clk)
	begin : drive_ready
		logic b0;
		if (ready_mode == 1)
		begin
			rdy_lfsr = lfsr_step(rdy_lfsr);
			b0 = rdy_lfsr[0];
			rdy_lfsr = lfsr_step(rdy_lfsr);
			rx_ready = b0 | rdy_lfsr[0];	// ready about 3 cycles in 4
		end
		else
			rx_ready = (ready_mode == 0);
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge usr_clk);
		$display("timeout: rx output did not drain within %0d cycles", WATCHDOG_CYCLES);
		$display("checks: %0d  errors: %0d", n_checks, n_errors);
		$display("Regression failed");
		$finish;
	end

	// ========================================
	// output checks
	// ========================================
	task automatic check_beat();
		logic [DATA_W-1:0] want_data;
		logic [BCNT_W+2:0] want_flags;
		assert (exp_data.size() != 0) else
		begin
			$display("unexpected beat on the rx output during %s", test_name);
			n_errors++;
		end
		if (exp_data.size() != 0)
		begin
			want_data = exp_data.pop_front();
			want_flags = exp_flags.pop_front();
			n_checks++;
			assert (rx_data == want_data) else
			begin
				$display("mismatch %s data expected %h actual %h", test_name, want_data, rx_data);
				n_errors++;
			end
			assert ({rx_start, rx_end, rx_err, rx_bcnt} == want_flags) else
			begin
				$display("mismatch %s start/end/err/bcnt expected %b actual %b", test_name,
					want_flags, {rx_start, rx_end, rx_err, rx_bcnt});
				n_errors++;
			end
		end
	endtask

	always @(posedge usr_clk)
	begin
		if (usr_rst_)
		begin
			if (stalled)	// no transfer last edge, beat must hold
			begin
				assert (rx_valid && rx_data == stall_data &&
					{rx_start, rx_end, rx_err, rx_bcnt} == stall_flags) else
				begin
					$display("rx output changed while stalled during %s", test_name);
					n_errors++;
				end
			end
			if (rx_valid && rx_ready)
				check_beat();
			stalled = rx_valid && !rx_ready;
			stall_data = rx_data;
			stall_flags = {rx_start, rx_end, rx_err, rx_bcnt};
		end
	end

	task automatic check_count(input string what, input logic [CNT_W-1:0] actual,
		input int expected);
		n_checks++;
		assert (actual == CNT_W'(expected)) else
		begin
			$display("mismatch %s expected %0d actual %0d", what, expected, actual);
			n_errors++;
		end
	endtask

	task automatic set_ready_mode(input int m);
		@(posedge usr_clk);	// away from the ready driver's edge
		ready_mode = m;
	endtask

	task automatic wait_drain();
		while (exp_data.size() != 0 || rx_valid)
			@(negedge usr_clk);
		@(negedge usr_clk);	// counters settle
	endtask

	task automatic finish_run();
		$display("checks: %0d  errors: %0d", n_checks, n_errors);
		if (n_errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	endtask

	// ========================================
	// test sequence
	// ========================================
	initial
	begin
		usr_rst_ = 1'b0;
		rx_en = 1'b1;
		rx_ready = 1'b1;
		xgmii_rxd = {LANES{XGMII_IDLE}};
		xgmii_rxc = '1;
		exp_pkts = 0;
		exp_bytes = 0;
		exp_errs = 0;
		exp_drops = 0;
		n_checks = 0;
		n_errors = 0;
		pay_lfsr = 32'h47d8_9d31;
		rdy_lfsr = 32'h47d8_9d31;
		ready_mode = 0;
		track_room = 1'b0;
		room_used = 0;
		stalled = 1'b0;
		test_name = "reset";
		repeat (10) @(negedge usr_clk);
		usr_rst_ = 1'b1;
		@(negedge usr_clk);
		n_checks++;
		assert (!rx_valid && rx_pkt_cnt == '0 && rx_byte_cnt == '0 &&
			rx_err_cnt == '0 && rx_drop_cnt == '0) else
		begin
			$display("rx_valid or a counter not cleared by reset");
			n_errors++;
		end
		n_checks++;
		assert (uut.parser.state == PS_IDLE && uut.empty && !uut.wr_en) else
		begin
			$display("parser not idle or packet buffer not empty after reset");
			n_errors++;
		end

		test_name = "lengths";	// every terminate lane
		set_ready_mode(1);
		for (int len = 1; len <= 128; len++)
			send_frame(len, 1'b0);
		wait_drain();

		test_name = "oversize";
		send_frame(200, 1'b0);
		send_frame(40, 1'b0);	// must follow intact
		wait_drain();

		test_name = "error_char";
		send_frame(50, 1'b1);
		wait_drain();
		check_count("error_char rx_err_cnt", rx_err_cnt, exp_errs);

		test_name = "overrun";	// buffer fills behind a stalled user
		set_ready_mode(2);
		track_room = 1'b1;
		room_used = 0;
		repeat (STALL_FRAMES) send_frame(64, 1'b0);
		track_room = 1'b0;
		set_ready_mode(0);
		wait_drain();
		check_count("overrun rx_drop_cnt", rx_drop_cnt, exp_drops);

		test_name = "rx_disabled";
		rx_en = 1'b0;
		repeat (3) send_frame(32, 1'b0);
		rx_en = 1'b1;
		send_frame(24, 1'b0);	// admitted again
		wait_drain();

		test_name = "totals";
		check_count("totals rx_pkt_cnt", rx_pkt_cnt, exp_pkts);
		check_count("totals rx_byte_cnt", rx_byte_cnt, exp_bytes);
		check_count("totals rx_err_cnt", rx_err_cnt, exp_errs);
		check_count("totals rx_drop_cnt", rx_drop_cnt, exp_drops);
		finish_run();
	end

endmodule

`default_nettype wire
